// File: logic/pp_link_pkg.sv
package pp_link_pkg;

    typedef logic [31:0] word_t;     // one link word
    typedef logic [63:0] rb_word_t;  // random-bit store entry, two words

    localparam int BUF_AW       = 6;   // message buffer, 64 words, header at 0
    localparam int MSG_MAX      = 63;  // largest payload in words
    localparam int HDR_KIND_LSB = 30;  // kind in hdr[31:30]
    localparam int RB_AW        = 3;
    localparam int RB_DEPTH     = 8;
    localparam int LINK_BASE    = 4;   // fixed link latency in cycles
    localparam int LINK_DLY_W   = $clog2(LINK_BASE + MSG_MAX + 1);

    typedef logic [BUF_AW-1:0] msg_size_t;

    typedef enum logic [1:0] {
        MSG_ER    = 2'd0,  // error-reconciliation data
        MSG_EV_RB = 2'd1   // error-verification random bits
    } msg_kind_e;

    // header word, kind on top, length at the bottom, rest zero
    function automatic word_t make_hdr(msg_kind_e kind, msg_size_t size);
        word_t hdr;
        hdr = '0;
        hdr[HDR_KIND_LSB +: 2] = kind;
        hdr[BUF_AW-1:0]        = size;
        return hdr;
    endfunction

    function automatic msg_kind_e hdr_kind(word_t hdr);
        return msg_kind_e'(hdr[HDR_KIND_LSB +: 2]);
    endfunction

    function automatic msg_size_t hdr_size(word_t hdr);
        return hdr[BUF_AW-1:0];
    endfunction

endpackage

// File: logic/payload_if.sv
`timescale 1ns/1ps

// decoded payload words, unpacker to router
interface payload_if import pp_link_pkg::*; ();

    logic      valid;  // one word this cycle
    msg_kind_e kind;   // kind from the header
    word_t     data;
    logic      first;  // first payload word of the message
    logic      last;   // final payload word

    modport src (
        output valid, kind, data, first, last
    );

    modport dst (
        input valid, kind, data, first, last
    );

endinterface

// File: logic/msg_buffer.sv
`timescale 1ns/1ps

// simple dual-port ram with one write port and a registered read port
module msg_buffer #(
    parameter type word_type = logic [31:0],
    parameter int  AW        = 6
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  word_type      wr_data,
    input  logic [AW-1:0] rd_addr,
    output word_type      rd_data
);

    word_type mem [0:(1<<AW)-1];  // 2**AW words

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // data one cycle after address
    end

endmodule

// File: logic/msg_packer.sv
`timescale 1ns/1ps

// alice side packetizer
// payload from addr 1 upward, header at addr 0 once the message is complete
module msg_packer import pp_link_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  msg_kind_e       in_kind,
    input  word_t           in_data,
    input  logic            in_last,
    output logic            buf_wr_en,
    output logic [BUF_AW-1:0] buf_wr_addr,
    output word_t           buf_wr_data,
    output logic            msg_stored,
    output msg_size_t       msg_size
);

    msg_size_t cnt;      // payload words stored so far
    msg_kind_e kind_q;   // kind of the first word
    logic      cnt_sat;  // buffer full, further words dropped

    assign cnt_sat = (cnt == MSG_MAX);

    // header write shares the port, it wins over payload
    assign buf_wr_en   = msg_stored | (in_valid & ~cnt_sat);
    assign buf_wr_addr = msg_stored ? '0 : cnt + 1'b1;
    assign buf_wr_data = msg_stored ? make_hdr(kind_q, cnt) : in_data;
    assign msg_size    = cnt;  // valid while msg_stored is high

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt        <= '0;
            kind_q     <= MSG_ER;
            msg_stored <= 1'b0;
        end else begin
            msg_stored <= in_valid & in_last;  // header goes out next cycle
            if (msg_stored) begin
                cnt <= '0;  // ready for the next message
            end else if (in_valid) begin
                if (cnt == '0) begin
                    kind_q <= in_kind;  // first word decides the kind
                end
                if (!cnt_sat) begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/link_model.sv
`timescale 1ns/1ps

// network model for the alice to bob direction
// busy from store until the receiver is done with the message
module link_model import pp_link_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      msg_stored,
    input  msg_size_t msg_size,
    input  logic      msg_done,
    output logic      tx_busy,
    output logic      msg_accessed
);

    typedef enum logic [1:0] {
        IDLE,     // link free
        XFER,     // message in flight
        DELIVER   // receiver is reading the buffer
    } state_e;

    state_e                state;
    logic [LINK_DLY_W-1:0] delay;  // cycles left in flight

    assign tx_busy      = (state != IDLE);
    assign msg_accessed = (state == XFER) && (delay == 1);  // single cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            delay <= '0;
        end else begin
            case (state)
                IDLE: if (msg_stored) begin
                    state <= XFER;
                    delay <= LINK_DLY_W'(LINK_BASE) + LINK_DLY_W'(msg_size);  // grows with size
                end
                XFER: begin
                    delay <= delay - 1'b1;
                    if (delay == 1) state <= DELIVER;  // handed over to bob
                end
                DELIVER: if (msg_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/msg_unpacker.sv
`timescale 1ns/1ps

// bob side unpacketizer
// header at addr 0 first, then the payload walked in address order
module msg_unpacker import pp_link_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              msg_accessed,
    input  word_t             buf_rd_data,
    output logic [BUF_AW-1:0] buf_rd_addr,
    output logic              msg_done,
    payload_if.src            pl
);

    typedef enum logic [1:0] {
        IDLE,
        HDR,   // header on buf_rd_data
        DATA   // one payload word per cycle
    } state_e;

    state_e    state;
    msg_kind_e kind_q;
    msg_size_t size_q;
    logic      hdr_empty;  // zero-length message
    logic      at_last;

    // rd addr runs one ahead of the word on buf_rd_data
    assign hdr_empty = (state == HDR) && (hdr_size(buf_rd_data) == '0);
    assign at_last   = (buf_rd_addr == size_q + 1'b1);

    assign pl.valid = (state == DATA);
    assign pl.kind  = kind_q;
    assign pl.data  = buf_rd_data;
    assign pl.first = (state == DATA) && (buf_rd_addr == 2);
    assign pl.last  = (state == DATA) && at_last;

    assign msg_done = hdr_empty | pl.last;  // nothing to emit when empty

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            buf_rd_addr <= '0;   // header address while idle
            kind_q      <= MSG_ER;
            size_q      <= '0;
        end else begin
            case (state)
                IDLE: if (msg_accessed) begin
                    state       <= HDR;
                    buf_rd_addr <= 1;  // prefetch first payload word
                end
                HDR: begin
                    kind_q <= hdr_kind(buf_rd_data);
                    size_q <= hdr_size(buf_rd_data);
                    if (hdr_empty) begin
                        state       <= IDLE;
                        buf_rd_addr <= '0;
                    end else begin
                        state       <= DATA;
                        buf_rd_addr <= 2;
                    end
                end
                DATA: begin
                    buf_rd_addr <= buf_rd_addr + 1'b1;
                    if (at_last) begin
                        state       <= IDLE;
                        buf_rd_addr <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/payload_router.sv
`timescale 1ns/1ps

// er words to the output stream, ev words paired into the random-bit store
module payload_router import pp_link_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ev_clear,
    input  logic [RB_AW-1:0] rb_rd_addr,
    payload_if.dst           pl,
    output logic             er_valid,
    output word_t            er_data,
    output logic             ev_full,
    output rb_word_t         rb_rd_data
);

    logic             ev_word;    // ev word that is kept
    logic             have_lo;    // low half waiting for its partner
    logic             pair_open;
    word_t            lo_q;
    logic             rb_wr_en;
    rb_word_t         rb_wr_data;
    logic [RB_AW-1:0] wr_ptr;

    assign ev_word   = pl.valid && (pl.kind == MSG_EV_RB) && !ev_full && !ev_clear;
    assign pair_open = have_lo && !pl.first;  // pairs never span messages

    // second word of a pair, or an odd word at the end padded with zero
    assign rb_wr_en   = ev_word && (pair_open || pl.last);
    assign rb_wr_data = pair_open ? {pl.data, lo_q} : {word_t'(0), pl.data};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            er_valid <= 1'b0;
            ev_full  <= 1'b0;
            wr_ptr   <= '0;
            have_lo  <= 1'b0;
        end else begin
            er_valid <= pl.valid && (pl.kind == MSG_ER);
            if (ev_clear) begin
                ev_full <= 1'b0;  // stored entries stay
                wr_ptr  <= '0;
                have_lo <= 1'b0;
            end else if (ev_word) begin
                if (rb_wr_en) begin
                    have_lo <= 1'b0;
                    wr_ptr  <= wr_ptr + 1'b1;
                    if (wr_ptr == RB_AW'(RB_DEPTH - 1)) ev_full <= 1'b1;  // last entry written
                end else begin
                    have_lo <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pl.valid && pl.kind == MSG_ER) er_data <= pl.data;
        if (ev_word && !rb_wr_en) lo_q <= pl.data;  // hold low half
    end

    msg_buffer #(
        .word_type (rb_word_t),
        .AW        (RB_AW)
    ) rb_store (
        .clk     (clk),
        .wr_en   (rb_wr_en),
        .wr_addr (wr_ptr),
        .wr_data (rb_wr_data),
        .rd_addr (rb_rd_addr),
        .rd_data (rb_rd_data)
    );

endmodule

// File: logic/pp_link_top.sv
`timescale 1ns/1ps

// alice to bob post-processing link
// packetizer, shared buffer, network model, unpacketizer, router
module pp_link_top import pp_link_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  msg_kind_e        in_kind,
    input  word_t            in_data,
    input  logic             in_last,
    input  logic             ev_clear,
    input  logic [RB_AW-1:0] rb_rd_addr,
    output logic             tx_busy,
    output logic             er_valid,
    output word_t            er_data,
    output logic             ev_full,
    output rb_word_t         rb_rd_data
);

    logic              buf_wr_en;
    logic [BUF_AW-1:0] buf_wr_addr;
    word_t             buf_wr_data;
    logic [BUF_AW-1:0] buf_rd_addr;
    word_t             buf_rd_data;
    logic              msg_stored;
    msg_size_t         msg_size;
    logic              msg_accessed;
    logic              msg_done;

    payload_if pl ();

    msg_packer i_msg_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_kind     (in_kind),
        .in_data     (in_data),
        .in_last     (in_last),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .msg_stored  (msg_stored),
        .msg_size    (msg_size)
    );

    // shared message buffer, alice writes and bob reads
    msg_buffer #(
        .word_type (word_t),
        .AW        (BUF_AW)
    ) msg_mem (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    link_model i_link_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_stored   (msg_stored),
        .msg_size     (msg_size),
        .msg_done     (msg_done),
        .tx_busy      (tx_busy),
        .msg_accessed (msg_accessed)
    );

    msg_unpacker i_msg_unpacker (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_accessed (msg_accessed),
        .buf_rd_data  (buf_rd_data),
        .buf_rd_addr  (buf_rd_addr),
        .msg_done     (msg_done),
        .pl           (pl.src)
    );

    payload_router i_payload_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .ev_clear   (ev_clear),
        .rb_rd_addr (rb_rd_addr),
        .pl         (pl.dst),
        .er_valid   (er_valid),
        .er_data    (er_data),
        .ev_full    (ev_full),
        .rb_rd_data (rb_rd_data)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

// 40 ns clock, rst_n low for the first 2 rising edges
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // half period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;  // released on the 2nd edge
    end

endmodule

// File: tb/pp_link_tb.sv
`timescale 1ns/1ps

// drives the link from tb/link_input.txt and checks stream, store and flags
module pp_link_tb import pp_link_pkg::*; ();

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    msg_kind_e        in_kind;
    word_t            in_data;
    logic             in_last;
    logic             ev_clear;
    logic [RB_AW-1:0] rb_rd_addr;
    logic             tx_busy;
    logic             er_valid;
    word_t            er_data;
    logic             ev_full;
    rb_word_t         rb_rd_data;

    word_t  er_q[$];    // er words seen on the output
    word_t  msg_q[$];   // words of the message being sent
    int     errors;
    int     test_errs;
    int     tests_run;
    int     tests_failed;
    int     cur_test;   // 0 while no test is open
    int     cycles;
    int     limit;      // grows with every message read

    int               fd;
    int               code;
    int               num;
    int               len;
    int               addr;
    logic [7:0]       cmd;
    logic [8*128-1:0] line;
    logic [1:0]       kind_v;
    word_t            w;
    rb_word_t         exp64;
    logic             exp_bit;

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pp_link_top i_pp_link_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_kind    (in_kind),
        .in_data    (in_data),
        .in_last    (in_last),
        .ev_clear   (ev_clear),
        .rb_rd_addr (rb_rd_addr),
        .tx_busy    (tx_busy),
        .er_valid   (er_valid),
        .er_data    (er_data),
        .ev_full    (ev_full),
        .rb_rd_data (rb_rd_data)
    );

    // er stream sampled mid cycle
    always @(negedge clk) begin
        if (er_valid) er_q.push_back(er_data);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
            test_errs++;
        end
    endtask

    task automatic finish_test();
        check_true(er_q.size() == 0,
                   $sformatf("test %0d left %0d unexpected ER words", cur_test, er_q.size()));
        er_q.delete();
        $display("test %0d: %s", cur_test, (test_errs == 0) ? "ok" : "failed");
        tests_run++;
        if (test_errs != 0) tests_failed++;
        test_errs = 0;
    endtask

    // one word per cycle and then wait for the link to go busy and idle again
    task automatic send_msg(input msg_kind_e kind, input int n);
        int wait_n;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_kind  <= kind;
            in_data  <= msg_q[i];
            in_last  <= (i == n - 1);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        wait_n = 0;
        @(negedge clk);
        while (!tx_busy && wait_n < 4) begin  // rises 2 cycles after in_last
            @(negedge clk);
            wait_n++;
        end
        check_true(tx_busy, "tx_busy did not rise after the message was sent");
        while (tx_busy) @(negedge clk);
        @(negedge clk);  // last er word reaches the monitor
    endtask

    task automatic read_store(input int a, input rb_word_t exp);
        @(posedge clk);
        rb_rd_addr <= RB_AW'(a);
        @(posedge clk);  // registered read
        @(negedge clk);
        check_value($sformatf("rb_rd_data[%0d]", a), rb_rd_data, exp);
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        ev_clear <= 1'b1;
        @(posedge clk);
        ev_clear <= 1'b0;
    endtask

    initial begin
        in_valid   <= 1'b0;
        in_kind    <= MSG_ER;
        in_data    <= '0;
        in_last    <= 1'b0;
        ev_clear   <= 1'b0;
        rb_rd_addr <= '0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        limit        = 100;  // reset and slack before any message

        // test 1 checks idle outputs after reset
        cur_test = 1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("tx_busy", 64'(tx_busy), 64'h0);
        check_value("er_valid", 64'(er_valid), 64'h0);
        check_value("ev_full", 64'(ev_full), 64'h0);
        finish_test();
        cur_test = 0;

        fd = $fopen("tb/link_input.txt", "r");
        check_true(fd != 0, "cannot open tb/link_input.txt");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": code = $fgets(line, fd);  // comment line
                    "T": begin
                        code = $fscanf(fd, "%d", num);
                        if (cur_test != 0) finish_test();
                        cur_test = num;
                        check_true(code == 1, "a T line has no test number");
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %d", kind_v, len);
                        check_true(code == 2, "an S line has no kind or length");
                        msg_q.delete();
                        for (int i = 0; i < len; i++) begin
                            code = $fscanf(fd, "%h", w);
                            check_true(code == 1, "an S line has fewer words than its length");
                            msg_q.push_back(w);
                        end
                        limit += LINK_BASE + len + 20;
                        send_msg(msg_kind_e'(kind_v), len);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h", w);
                        check_true(code == 1, "an E line has no word");
                        check_true(er_q.size() != 0, "an ER word was expected but none arrived");
                        if (er_q.size() != 0) check_value("er_data", 64'(er_q.pop_front()), 64'(w));
                    end
                    "R": begin
                        code = $fscanf(fd, "%d %h", addr, exp64);
                        check_true(code == 2, "an R line has no address or entry");
                        read_store(addr, exp64);
                    end
                    "F": begin
                        code = $fscanf(fd, "%h", exp_bit);
                        check_true(code == 1, "an F line has no flag value");
                        @(negedge clk);
                        check_value("ev_full", 64'(ev_full), 64'(exp_bit));
                    end
                    "C": pulse_clear();
                    default: check_true(1'b0, "unknown command in the input file");
                endcase
            end
            $fclose(fd);
            if (cur_test != 0) finish_test();
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/link_input.txt
# T test number | S kind len words | E er word | R addr entry | F ev_full | C clear
# kind 0 is er data, 1 is ev random bits; words and entries in hex, len and addr decimal
T 2
S 0 5 0badf00d 12345678 9abcdef0 deadbeef 00c0ffee
E 0badf00d
E 12345678
E 9abcdef0
E deadbeef
E 00c0ffee
F 0
T 3
S 1 4 10000000 10000001 10000002 10000003
R 0 1000000110000000
R 1 1000000310000002
F 0
T 4
S 1 3 20000000 20000001 20000002
R 2 2000000120000000
R 3 0000000020000002
F 0
T 5
S 1 8 30000000 30000001 30000002 30000003 30000004 30000005 30000006 30000007
R 4 3000000130000000
R 5 3000000330000002
R 6 3000000530000004
R 7 3000000730000006
F 1
S 1 2 40000000 40000001
R 0 1000000110000000
R 7 3000000730000006
F 1
C
F 0
S 1 2 50000000 50000001
R 0 5000000150000000
R 1 1000000310000002
F 0

// File: tb.f
logic/pp_link_pkg.sv
logic/payload_if.sv
logic/msg_buffer.sv
logic/msg_packer.sv
logic/link_model.sv
logic/msg_unpacker.sv
logic/payload_router.sv
logic/pp_link_top.sv
tb/tb_clock.sv
tb/pp_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pp_link_tb
RTL_TOP   ?= pp_link_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j 0 --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
